// ==== rtl/xcom_pkg.sv ====
// xcom package
// frame geometry, opcodes and the command word shared by the
// transmitter, receiver, command FIFO and executor of the link
package xcom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////////////////////
  // header is opcode in the upper nibble, argument in the lower one
  localparam int XCOM_OP_W    = 4;
  localparam int XCOM_ARG_W   = 4;
  localparam int XCOM_HDR_W   = XCOM_OP_W + XCOM_ARG_W;
  localparam int XCOM_DATA_W  = 32;
  // header first, then data, MSB first on the wire
  localparam int XCOM_FRAME_W = XCOM_HDR_W + XCOM_DATA_W;
  localparam int XCOM_BCNT_W  = $clog2(XCOM_FRAME_W);

  // strobe idle time that drops a partial frame at the receiver
  localparam int XCOM_RX_TIMEOUT = 64;
  localparam int XCOM_IDLE_W     = $clog2(XCOM_RX_TIMEOUT + 1);

  // executor memory and receive buffer sizes
  localparam int XCOM_MEM_DEPTH  = 16;
  localparam int XCOM_FIFO_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [XCOM_OP_W-1:0] XCOM_SET_ID     = 4'd0;
  localparam logic [XCOM_OP_W-1:0] XCOM_WRITE_FLAG = 4'd1;
  localparam logic [XCOM_OP_W-1:0] XCOM_WRITE_REG  = 4'd2;
  localparam logic [XCOM_OP_W-1:0] XCOM_WRITE_MEM  = 4'd3;

  // one received command, laid out in wire order
  typedef struct packed {
    logic [XCOM_HDR_W-1:0]  header;
    logic [XCOM_DATA_W-1:0] data;
  } xcom_cmd_t;

endpackage

// ==== rtl/xcom_tx_ser.sv ====
// xcom link transmitter
// takes one host command over a four-phase req/ack port and sends it as
// a 40 bit frame on a data wire plus a toggling strobe wire
`timescale 1ns/1ps

module xcom_tx_ser import xcom_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rstn,
  input  logic                   i_req,
  input  logic [XCOM_HDR_W-1:0]  i_header,
  input  logic [XCOM_DATA_W-1:0] i_data,
  input  logic [3:0]             i_cfg_tick,
  output logic                   o_ack,
  output logic                   o_tx_ready,
  output logic                   o_xcom_data,
  output logic                   o_xcom_clk
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_ACK
  } tx_state_t;

  tx_state_t               state_q;
  logic                    req_q;
  logic                    req_rise;
  logic [3:0]              tick_q;
  logic                    tick_end;
  // low while waiting to toggle the strobe, high while holding the bit
  logic                    half_q;
  logic [XCOM_BCNT_W-1:0]  bit_q;
  logic                    last_bit;
  logic                    shift_step;
  logic [XCOM_FRAME_W-1:0] shift_q;

  assign req_rise   = i_req & ~req_q;
  assign tick_end   = (tick_q == i_cfg_tick);
  assign last_bit   = (bit_q == XCOM_BCNT_W'(XCOM_FRAME_W - 1));
  // move to the next bit at the end of the second half period
  assign shift_step = (state_q == ST_SHIFT) & tick_end & half_q & ~last_bit;

  // host may only start a new command once the previous one is closed
  assign o_tx_ready = (state_q == ST_IDLE) & ~i_req;

  ////////////////////////////////////////////////////////////////////////////
  // control FSM and wire drivers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rstn) begin
      state_q     <= ST_IDLE;
      req_q       <= 1'b0;
      tick_q      <= '0;
      half_q      <= 1'b0;
      bit_q       <= '0;
      o_ack       <= 1'b0;
      o_xcom_data <= 1'b0;
      o_xcom_clk  <= 1'b0;
    end else begin
      req_q <= i_req;
      case (state_q)
        ST_IDLE: begin
          if (req_rise) begin
            state_q     <= ST_SHIFT;
            tick_q      <= '0;
            half_q      <= 1'b0;
            bit_q       <= '0;
            // first bit goes out with the latch
            o_xcom_data <= i_header[XCOM_HDR_W-1];
          end
        end
        ST_SHIFT: begin
          if (tick_end) begin
            tick_q <= '0;
            if (!half_q) begin
              // data has settled, one strobe edge per bit
              o_xcom_clk <= ~o_xcom_clk;
              half_q     <= 1'b1;
            end else begin
              half_q <= 1'b0;
              if (last_bit) begin
                // 40 toggles leave the strobe low again
                state_q     <= ST_ACK;
                o_ack       <= 1'b1;
                o_xcom_data <= 1'b0;
              end else begin
                bit_q       <= bit_q + 1'b1;
                o_xcom_data <= shift_q[XCOM_FRAME_W-2];
              end
            end
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        ST_ACK: begin
          // close the handshake once the host lets go
          if (!i_req) begin
            o_ack   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // frame shifter, msb is the bit on the wire
  always_ff @(posedge i_clk) begin
    if ((state_q == ST_IDLE) && req_rise) begin
      shift_q <= {i_header, i_data};
    end else if (shift_step) begin
      shift_q <= shift_q << 1;
    end
  end

endmodule

// ==== rtl/xcom_rx_deser.sv ====
// xcom link receiver
// samples the data wire on every strobe toggle and hands out each
// complete 40 bit frame as one command with a single cycle push
`timescale 1ns/1ps

module xcom_rx_deser import xcom_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rstn,
  input  logic      i_xcom_data,
  input  logic      i_xcom_clk,
  output logic      o_push,
  output xcom_cmd_t o_cmd
);

  logic                    clk_q;
  logic                    clk_qq;
  logic                    data_q;
  logic                    edge_s;
  logic [XCOM_BCNT_W-1:0]  bit_q;
  logic [XCOM_IDLE_W-1:0]  idle_q;
  logic                    push_q;
  logic [XCOM_FRAME_W-1:0] sr_q;

  // either strobe direction marks a bit
  assign edge_s = clk_q ^ clk_qq;

  ////////////////////////////////////////////////////////////////////////////
  // input registers, bit counter, idle timeout
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rstn) begin
      clk_q  <= 1'b0;
      clk_qq <= 1'b0;
      data_q <= 1'b0;
      bit_q  <= '0;
      idle_q <= '0;
      push_q <= 1'b0;
    end else begin
      // strobe and data pass the same register stage
      clk_q  <= i_xcom_clk;
      clk_qq <= clk_q;
      data_q <= i_xcom_data;
      push_q <= 1'b0;
      if (edge_s) begin
        idle_q <= '0;
        if (bit_q == XCOM_BCNT_W'(XCOM_FRAME_W - 1)) begin
          bit_q  <= '0;
          push_q <= 1'b1;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end else if (idle_q == XCOM_IDLE_W'(XCOM_RX_TIMEOUT)) begin
        // strobe went quiet mid frame
        bit_q <= '0;
      end else begin
        idle_q <= idle_q + 1'b1;
      end
    end
  end

  // deserializer, first bit ends up at the msb
  always_ff @(posedge i_clk) begin
    if (edge_s) begin
      sr_q <= {sr_q[XCOM_FRAME_W-2:0], data_q};
    end
  end

  // shifter holds the whole frame while push is high
  assign o_cmd  = xcom_cmd_t'(sr_q);
  assign o_push = push_q;

endmodule

// ==== rtl/xcom_cmd_fifo.sv ====
// command FIFO
// circular buffer between the link receiver and the executor, with a
// four-phase req/ack read side and a sticky overflow flag
`timescale 1ns/1ps

module xcom_cmd_fifo import xcom_pkg::*; #(
  parameter type T     = xcom_cmd_t,
  parameter int  DEPTH = 4
) (
  input  logic i_clk,
  input  logic i_rstn,
  input  logic i_push,
  input  T     i_data,
  output logic o_req,
  input  logic i_ack,
  output T     o_data,
  output logic o_overflow
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T                mem_q [DEPTH];
  logic [AW-1:0]   wr_q;
  logic [AW-1:0]   rd_q;
  logic [CW-1:0]   cnt_q;
  logic [CW-1:0]   cnt_n;
  logic            ack_q;
  logic            req_q;
  logic            push_ok;
  logic            pop;

  // a push into a full buffer is lost
  assign push_ok = i_push & (cnt_q != CW'(DEPTH));
  // entry leaves on the rising edge of ack
  assign pop     = i_ack & ~ack_q;
  assign cnt_n   = cnt_q + CW'(push_ok) - CW'(pop);

  ////////////////////////////////////////////////////////////////////////////
  // pointers, count and read handshake
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rstn) begin
      wr_q       <= '0;
      rd_q       <= '0;
      cnt_q      <= '0;
      ack_q      <= 1'b0;
      req_q      <= 1'b0;
      o_overflow <= 1'b0;
    end else begin
      ack_q <= i_ack;
      cnt_q <= cnt_n;
      if (push_ok) begin
        wr_q <= (wr_q == AW'(DEPTH - 1)) ? '0 : wr_q + 1'b1;
      end
      if (pop) begin
        rd_q <= (rd_q == AW'(DEPTH - 1)) ? '0 : rd_q + 1'b1;
      end
      // sticky until reset
      if (i_push && !push_ok) begin
        o_overflow <= 1'b1;
      end
      // req stays low while ack is up, returns once ack has dropped
      req_q <= ~i_ack & (cnt_n != '0);
    end
  end

  // storage
  always_ff @(posedge i_clk) begin
    if (push_ok) begin
      mem_q[wr_q] <= i_data;
    end
  end

  assign o_req  = req_q;
  assign o_data = mem_q[rd_q];

endmodule

// ==== rtl/xcom_exec.sv ====
// command executor
// applies one command per four-phase request: board id, flag, the two
// data registers with a valid pulse, and a 16 word memory
`timescale 1ns/1ps

module xcom_exec import xcom_pkg::*; (
  input  logic                               i_clk,
  input  logic                               i_rstn,
  input  logic                               i_req,
  input  xcom_cmd_t                          i_cmd,
  output logic                               o_ack,
  input  logic [$clog2(XCOM_MEM_DEPTH)-1:0]  i_mem_addr,
  output logic [XCOM_DATA_W-1:0]             o_mem_data,
  output logic                               o_qp_flag,
  output logic                               o_qp_valid,
  output logic [XCOM_DATA_W-1:0]             o_qp_data1,
  output logic [XCOM_DATA_W-1:0]             o_qp_data2,
  output logic [XCOM_ARG_W-1:0]              o_xcom_id
);

  logic [XCOM_OP_W-1:0]   op_s;
  logic [XCOM_ARG_W-1:0]  arg_s;
  logic                   exec_s;
  logic [XCOM_DATA_W-1:0] mem_q [XCOM_MEM_DEPTH];

  // header split
  assign op_s  = i_cmd.header[XCOM_HDR_W-1 -: XCOM_OP_W];
  assign arg_s = i_cmd.header[XCOM_ARG_W-1:0];

  // only the first cycle of a request does work
  assign exec_s = i_req & ~o_ack;

  ////////////////////////////////////////////////////////////////////////////
  // decode and state update
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rstn) begin
      o_ack      <= 1'b0;
      o_qp_flag  <= 1'b0;
      o_qp_valid <= 1'b0;
      o_qp_data1 <= '0;
      o_qp_data2 <= '0;
      o_xcom_id  <= '0;
      for (int i = 0; i < XCOM_MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      // ack follows req one cycle later, both edges
      o_ack      <= i_req;
      o_qp_valid <= 1'b0;
      if (exec_s) begin
        case (op_s)
          XCOM_SET_ID: begin
            o_xcom_id <= arg_s;
          end
          XCOM_WRITE_FLAG: begin
            o_qp_flag <= arg_s[0];
          end
          XCOM_WRITE_REG: begin
            // arg bit 0 picks data2
            if (arg_s[0]) begin
              o_qp_data2 <= i_cmd.data;
            end else begin
              o_qp_data1 <= i_cmd.data;
            end
            o_qp_valid <= 1'b1;
          end
          XCOM_WRITE_MEM: begin
            mem_q[arg_s] <= i_cmd.data;
          end
          default: begin
            // unknown opcode, nothing changes
          end
        endcase
      end
    end
  end

  // async read port
  assign o_mem_data = mem_q[i_mem_addr];

endmodule

// ==== rtl/xcom_link_top.sv ====
// xcom link top
// host port into the transmitter, link wires into the receiver, then
// the command FIFO and the executor that owns the visible state
`timescale 1ns/1ps

module xcom_link_top import xcom_pkg::*; (
  input  logic                               i_clk,
  input  logic                               i_rstn,
  // host command port
  input  logic                               i_req,
  input  logic [XCOM_HDR_W-1:0]              i_header,
  input  logic [XCOM_DATA_W-1:0]             i_data,
  output logic                               o_ack,
  output logic                               o_tx_ready,
  input  logic [3:0]                         i_cfg_tick,
  // link wires
  input  logic                               i_xcom_data,
  input  logic                               i_xcom_clk,
  output logic                               o_xcom_data,
  output logic                               o_xcom_clk,
  // executor state
  input  logic [$clog2(XCOM_MEM_DEPTH)-1:0]  i_mem_addr,
  output logic [XCOM_DATA_W-1:0]             o_mem_data,
  output logic                               o_qp_flag,
  output logic                               o_qp_valid,
  output logic [XCOM_DATA_W-1:0]             o_qp_data1,
  output logic [XCOM_DATA_W-1:0]             o_qp_data2,
  output logic [XCOM_ARG_W-1:0]              o_xcom_id,
  output logic                               o_overflow
);

  logic      rx_push;
  xcom_cmd_t rx_cmd;
  logic      fifo_req;
  xcom_cmd_t fifo_cmd;
  logic      exec_ack;

  ////////////////////////////////////////////////////////////////////////////
  // send side
  ////////////////////////////////////////////////////////////////////////////
  xcom_tx_ser u_tx_ser (
    .i_clk       (i_clk),
    .i_rstn      (i_rstn),
    .i_req       (i_req),
    .i_header    (i_header),
    .i_data      (i_data),
    .i_cfg_tick  (i_cfg_tick),
    .o_ack       (o_ack),
    .o_tx_ready  (o_tx_ready),
    .o_xcom_data (o_xcom_data),
    .o_xcom_clk  (o_xcom_clk)
  );

  ////////////////////////////////////////////////////////////////////////////
  // receive side, receiver -> FIFO -> executor
  ////////////////////////////////////////////////////////////////////////////
  xcom_rx_deser u_rx_deser (
    .i_clk       (i_clk),
    .i_rstn      (i_rstn),
    .i_xcom_data (i_xcom_data),
    .i_xcom_clk  (i_xcom_clk),
    .o_push      (rx_push),
    .o_cmd       (rx_cmd)
  );

  xcom_cmd_fifo #(
    .T     (xcom_cmd_t),
    .DEPTH (XCOM_FIFO_DEPTH)
  ) u_cmd_fifo (
    .i_clk      (i_clk),
    .i_rstn     (i_rstn),
    .i_push     (rx_push),
    .i_data     (rx_cmd),
    .o_req      (fifo_req),
    .i_ack      (exec_ack),
    .o_data     (fifo_cmd),
    .o_overflow (o_overflow)
  );

  xcom_exec u_exec (
    .i_clk      (i_clk),
    .i_rstn     (i_rstn),
    .i_req      (fifo_req),
    .i_cmd      (fifo_cmd),
    .o_ack      (exec_ack),
    .i_mem_addr (i_mem_addr),
    .o_mem_data (o_mem_data),
    .o_qp_flag  (o_qp_flag),
    .o_qp_valid (o_qp_valid),
    .o_qp_data1 (o_qp_data1),
    .o_qp_data2 (o_qp_data2),
    .o_xcom_id  (o_xcom_id)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset
// 20 ns clock, synchronous active low reset held for four cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rstn
);

  // 50 MHz
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // release just after an edge, like any other stimulus
  initial begin
    o_rstn = 1'b0;
    repeat (4) @(posedge o_clk);
    #2;
    o_rstn = 1'b1;
  end

endmodule

// ==== verif/tb_xcom_link.sv ====
// xcom link testbench
// sends a table of host commands through the serial loopback, checks
// the executor state against a reference model, then breaks the loop
// and overruns the command FIFO with frames driven on the wires
`timescale 1ns/1ps

module tb_xcom_link import xcom_pkg::*; ();

  localparam int          TIMEOUT_CYC = 4000;
  localparam int          MA_W        = $clog2(XCOM_MEM_DEPTH);
  localparam int unsigned SEED        = 32'hed52e09e;

  // one table row holds the command fields and the link rate
  typedef struct packed {
    logic [XCOM_OP_W-1:0]   op;
    logic [XCOM_ARG_W-1:0]  arg;
    logic [XCOM_DATA_W-1:0] data;
    logic [3:0]             tick;
  } entry_t;

  logic                   clk;
  logic                   rstn;
  logic                   req;
  logic [XCOM_HDR_W-1:0]  header;
  logic [XCOM_DATA_W-1:0] data;
  logic [3:0]             cfg_tick;
  logic [MA_W-1:0]        mem_addr;
  // loopback select and the wires driven in the overflow test
  logic                   loop_en;
  logic                   drv_xdata;
  logic                   drv_xclk;
  logic                   xdata_w;
  logic                   xclk_w;
  logic                   o_ack;
  logic                   o_tx_ready;
  logic                   o_xcom_data;
  logic                   o_xcom_clk;
  logic [XCOM_DATA_W-1:0] o_mem_data;
  logic                   o_qp_flag;
  logic                   o_qp_valid;
  logic [XCOM_DATA_W-1:0] o_qp_data1;
  logic [XCOM_DATA_W-1:0] o_qp_data2;
  logic [XCOM_ARG_W-1:0]  o_xcom_id;
  logic                   o_overflow;

  // reference model of the executor state
  logic [XCOM_ARG_W-1:0]  exp_id;
  logic                   exp_flag;
  logic [XCOM_DATA_W-1:0] exp_d1;
  logic [XCOM_DATA_W-1:0] exp_d2;
  logic [XCOM_DATA_W-1:0] exp_mem [XCOM_MEM_DEPTH];
  entry_t                 table_q [$];

  assign xdata_w = loop_en ? o_xcom_data : drv_xdata;
  assign xclk_w  = loop_en ? o_xcom_clk : drv_xclk;

  tb_clk_gen u_clk_gen (
    .o_clk  (clk),
    .o_rstn (rstn)
  );

  xcom_link_top i_xcom_link_top (
    .i_clk       (clk),
    .i_rstn      (rstn),
    .i_req       (req),
    .i_header    (header),
    .i_data      (data),
    .o_ack       (o_ack),
    .o_tx_ready  (o_tx_ready),
    .i_cfg_tick  (cfg_tick),
    .i_xcom_data (xdata_w),
    .i_xcom_clk  (xclk_w),
    .o_xcom_data (o_xcom_data),
    .o_xcom_clk  (o_xcom_clk),
    .i_mem_addr  (mem_addr),
    .o_mem_data  (o_mem_data),
    .o_qp_flag   (o_qp_flag),
    .o_qp_valid  (o_qp_valid),
    .o_qp_data1  (o_qp_data1),
    .o_qp_data2  (o_qp_data2),
    .o_xcom_id   (o_xcom_id),
    .o_overflow  (o_overflow)
  );

  ////////////////////////////////////////////////////////////////////////////
  // error handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abort_run(input string msg);
    $display("%0d ns %s", $time, msg);
    stop_run();
  endtask

  task automatic check_word(input string name, input logic [XCOM_DATA_W-1:0] exp,
                            input logic [XCOM_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_id(input string name, input logic [XCOM_ARG_W-1:0] exp,
                          input logic [XCOM_ARG_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0d ns %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cmd(input string name, input xcom_cmd_t exp, input xcom_cmd_t act);
    if (act !== exp) begin
      $display("[ERROR] %0d ns %s expected %h/%h actual %h/%h", $time, name,
               exp.header, exp.data, act.header, act.data);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model and helpers
  ////////////////////////////////////////////////////////////////////////////
  // one cycle, then the drive point just after the edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  function automatic entry_t make_entry(input logic [XCOM_OP_W-1:0] op,
                                        input logic [XCOM_ARG_W-1:0] arg,
                                        input logic [3:0] tick);
    entry_t e;
    e.op   = op;
    e.arg  = arg;
    e.data = $urandom;
    e.tick = tick;
    return e;
  endfunction

  // opcode rules of the link
  task automatic model_apply(input logic [XCOM_OP_W-1:0] op, input logic [XCOM_ARG_W-1:0] arg,
                             input logic [XCOM_DATA_W-1:0] wdata);
    case (op)
      XCOM_SET_ID:     exp_id = arg;
      XCOM_WRITE_FLAG: exp_flag = arg[0];
      XCOM_WRITE_REG: begin
        if (arg[0]) begin
          exp_d2 = wdata;
        end else begin
          exp_d1 = wdata;
        end
      end
      XCOM_WRITE_MEM:  exp_mem[arg] = wdata;
      default: begin
        // ignored opcode
      end
    endcase
  endtask

  task automatic check_state();
    check_id("o_xcom_id", exp_id, o_xcom_id);
    check_bit("o_qp_flag", exp_flag, o_qp_flag);
    check_word("o_qp_data1", exp_d1, o_qp_data1);
    check_word("o_qp_data2", exp_d2, o_qp_data2);
  endtask

  // combinational read port is sampled one ns after the address
  task automatic check_mem_word(input int addr);
    step();
    mem_addr = MA_W'(addr);
    #1;
    check_word($sformatf("o_mem_data[%0d]", addr), exp_mem[addr], o_mem_data);
  endtask

  task automatic check_all_mem();
    for (int a = 0; a < XCOM_MEM_DEPTH; a++) begin
      check_mem_word(a);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host port, executor and wire drivers
  ////////////////////////////////////////////////////////////////////////////
  task automatic host_send(input xcom_cmd_t cmd, input logic [3:0] tick);
    int n;
    check_bit("o_ack", 1'b0, o_ack);
    check_bit("o_tx_ready", 1'b1, o_tx_ready);
    cfg_tick = tick;
    header   = cmd.header;
    data     = cmd.data;
    req      = 1'b1;
    step();
    // no ack while the frame has just started
    check_bit("o_ack", 1'b0, o_ack);
    check_bit("o_tx_ready", 1'b0, o_tx_ready);
    n = 0;
    while (o_ack !== 1'b1) begin
      if (n == TIMEOUT_CYC) begin
        abort_run("timeout waiting for the transmitter to raise o_ack");
      end
      step();
      n++;
    end
    // each bit is held for two halves of tick+1 cycles
    check_word("o_ack latency in cycles", 2 * XCOM_FRAME_W * (int'(tick) + 1), n);
    req = 1'b0;
    n = 0;
    step();
    while (o_ack !== 1'b0) begin
      if (n == TIMEOUT_CYC) begin
        abort_run("timeout waiting for the transmitter to drop o_ack");
      end
      step();
      n++;
    end
    check_bit("o_tx_ready", 1'b1, o_tx_ready);
    // strobe is back at rest after the frame
    check_bit("o_xcom_clk", 1'b0, o_xcom_clk);
  endtask

  // executor ack marks the cycle its update lands
  task automatic wait_apply(input logic exp_valid);
    int n;
    n = 0;
    while (i_xcom_link_top.exec_ack !== 1'b0) begin
      if (n == TIMEOUT_CYC) begin
        abort_run("timeout waiting for the executor ack to fall");
      end
      step();
      n++;
    end
    n = 0;
    while (i_xcom_link_top.exec_ack !== 1'b1) begin
      if (n == TIMEOUT_CYC) begin
        abort_run("timeout waiting for the executor to apply a command");
      end
      step();
      n++;
    end
    check_bit("o_qp_valid", exp_valid, o_qp_valid);
    step();
    // single cycle pulse
    check_bit("o_qp_valid", 1'b0, o_qp_valid);
  endtask

  task automatic run_entry(input entry_t e);
    xcom_cmd_t cmd;
    cmd.header = {e.op, e.arg};
    cmd.data   = e.data;
    fork
      host_send(cmd, e.tick);
      wait_apply(e.op == XCOM_WRITE_REG);
    join
    model_apply(e.op, e.arg, e.data);
    check_state();
    if (e.op == XCOM_WRITE_MEM) begin
      check_mem_word(int'(e.arg));
    end
  endtask

  // one strobe toggle per cycle at the fastest legal rate
  task automatic send_wire_frame(input xcom_cmd_t cmd);
    logic [XCOM_FRAME_W-1:0] bits;
    bits = cmd;
    for (int i = XCOM_FRAME_W - 1; i >= 0; i--) begin
      step();
      drv_xdata = bits[i];
      drv_xclk  = ~drv_xclk;
    end
  endtask

  task automatic overflow_test();
    xcom_cmd_t burst [XCOM_FIFO_DEPTH+1];
    int        n;
    for (int i = 0; i < XCOM_FIFO_DEPTH; i++) begin
      burst[i].header = {XCOM_WRITE_REG, 4'h0};
      burst[i].data   = $urandom;
    end
    // the extra frame must never reach memory
    burst[XCOM_FIFO_DEPTH].header = {XCOM_WRITE_MEM, 4'hE};
    burst[XCOM_FIFO_DEPTH].data   = ~exp_mem[14];
    check_bit("o_overflow", 1'b0, o_overflow);
    // executor sees no request while the burst lands
    force i_xcom_link_top.fifo_req = 1'b0;
    loop_en = 1'b0;
    for (int i = 0; i <= XCOM_FIFO_DEPTH; i++) begin
      send_wire_frame(burst[i]);
    end
    n = 0;
    while (o_overflow !== 1'b1) begin
      if (n == TIMEOUT_CYC) begin
        abort_run("timeout waiting for o_overflow after the burst");
      end
      step();
      n++;
    end
    check_cmd("fifo head", burst[0], i_xcom_link_top.fifo_cmd);
    release i_xcom_link_top.fifo_req;
    loop_en = 1'b1;
    // drained oldest first
    for (int i = 0; i < XCOM_FIFO_DEPTH; i++) begin
      wait_apply(1'b1);
      model_apply(XCOM_WRITE_REG, 4'h0, burst[i].data);
      check_state();
    end
    check_bit("o_overflow", 1'b1, o_overflow);
    check_all_mem();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int n;
    void'($urandom(SEED));
    req       = 1'b0;
    header    = '0;
    data      = '0;
    cfg_tick  = '0;
    mem_addr  = '0;
    loop_en   = 1'b1;
    drv_xdata = 1'b0;
    drv_xclk  = 1'b0;
    exp_id    = '0;
    exp_flag  = 1'b0;
    exp_d1    = '0;
    exp_d2    = '0;
    for (int a = 0; a < XCOM_MEM_DEPTH; a++) begin
      exp_mem[a] = '0;
    end

    // rows are opcode, argument and link rate
    // data words come from the seeded generator
    table_q.push_back(make_entry(XCOM_WRITE_REG, 4'h0, 4'd0));
    table_q.push_back(make_entry(XCOM_WRITE_REG, 4'h1, 4'd1));
    table_q.push_back(make_entry(XCOM_WRITE_FLAG, 4'h1, 4'd2));
    table_q.push_back(make_entry(XCOM_WRITE_MEM, 4'h3, 4'd0));
    table_q.push_back(make_entry(XCOM_WRITE_MEM, 4'h7, 4'd5));
    table_q.push_back(make_entry(XCOM_WRITE_MEM, 4'hF, 4'd15));
    table_q.push_back(make_entry(XCOM_SET_ID, 4'h5, 4'd3));
    table_q.push_back(make_entry(4'h9, 4'h2, 4'd0));
    table_q.push_back(make_entry(XCOM_WRITE_FLAG, 4'h0, 4'd7));
    table_q.push_back(make_entry(XCOM_WRITE_REG, 4'h0, 4'd15));
    table_q.push_back(make_entry(XCOM_WRITE_MEM, 4'h0, 4'd1));
    table_q.push_back(make_entry(4'hF, 4'h1, 4'd2));
    table_q.push_back(make_entry(XCOM_SET_ID, 4'hA, 4'd9));
    table_q.push_back(make_entry(XCOM_WRITE_REG, 4'h3, 4'd4));

    n = 0;
    while (rstn !== 1'b1) begin
      if (n == TIMEOUT_CYC) begin
        abort_run("timeout waiting for reset release");
      end
      step();
      n++;
    end
    step();

    // state right after reset
    check_state();
    check_bit("o_ack", 1'b0, o_ack);
    check_bit("o_qp_valid", 1'b0, o_qp_valid);
    check_bit("o_overflow", 1'b0, o_overflow);
    check_bit("o_xcom_clk", 1'b0, o_xcom_clk);
    check_bit("o_xcom_data", 1'b0, o_xcom_data);
    check_all_mem();

    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    check_all_mem();

    overflow_test();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/xcom_pkg.sv
rtl/xcom_tx_ser.sv
rtl/xcom_rx_deser.sv
rtl/xcom_cmd_fifo.sv
rtl/xcom_exec.sv
rtl/xcom_link_top.sv
verif/tb_clk_gen.sv
verif/tb_xcom_link.sv

// ==== Bender.yml ====
package:
  name: xcom_link

sources:
  - rtl/xcom_pkg.sv
  - rtl/xcom_tx_ser.sv
  - rtl/xcom_rx_deser.sv
  - rtl/xcom_cmd_fifo.sv
  - rtl/xcom_exec.sv
  - rtl/xcom_link_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_xcom_link.sv
